// ==== hw/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] half_t;

	localparam int N_PADS = 23;
	typedef logic [N_PADS-1:0] pads_t;

	// Top address nibble picks the slave
	localparam int SLAVE_SEL_MSB = 31;
	localparam int SLAVE_SEL_LSB = 28;
	localparam logic [3:0] SRAM_REGION = 4'h0;
	localparam logic [3:0] GPIO_REGION = 4'h4;

	localparam addr_t GPIO_OUT_OFS = 32'h0;
	localparam addr_t GPIO_OE_OFS  = 32'h4;
	localparam addr_t GPIO_IN_OFS  = 32'h8;

	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_e;

	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_e;

	typedef enum logic {
		HRESP_OKAY  = 1'b0,
		HRESP_ERROR = 1'b1
	} hresp_e;

	typedef enum logic [1:0] {
		SRAM_IDLE,
		SRAM_LOW,
		SRAM_HIGH,
		SRAM_DONE
	} sram_state_e;

endpackage

`default_nettype wire

// ==== hw/ahb_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_splitter import soc_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  addr_t   haddr,
	input  htrans_e htrans,
	input  logic    hready,
	output logic    hsel_sram,
	output logic    hsel_gpio,
	input  word_t   hrdata_sram,
	input  word_t   hrdata_gpio,
	input  logic    hready_resp_sram,
	input  logic    hready_resp_gpio,
	input  hresp_e  hresp_sram,
	input  hresp_e  hresp_gpio,
	output word_t   hrdata,
	output logic    hready_resp,
	output hresp_e  hresp
);

	logic [SLAVE_SEL_MSB-SLAVE_SEL_LSB:0] region;
	logic gpio_ofs_ok;
	logic active;
	logic unmapped;
	logic dph_sram;
	logic dph_gpio;
	logic err_first;
	logic err_second;

	assign region = haddr[SLAVE_SEL_MSB:SLAVE_SEL_LSB];
	// Registers are word sized, nothing lives past the IN word
	assign gpio_ofs_ok = haddr[SLAVE_SEL_LSB-1:2] <= GPIO_IN_OFS[SLAVE_SEL_LSB-1:2];
	assign active = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

	assign hsel_sram = region == SRAM_REGION;
	assign hsel_gpio = (region == GPIO_REGION) && gpio_ofs_ok;
	assign unmapped = active && !hsel_sram && !hsel_gpio;

	// Data-phase owner, plus the default slave's two error cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_sram <= 1'b0;
			dph_gpio <= 1'b0;
			err_first <= 1'b0;
			err_second <= 1'b0;
		end else begin
			err_first <= hready && unmapped;
			err_second <= err_first;
			if (hready) begin
				dph_sram <= hsel_sram && active;
				dph_gpio <= hsel_gpio && active;
			end
		end
	end

	always_comb begin
		if (dph_sram) begin
			hrdata = hrdata_sram;
			hready_resp = hready_resp_sram;
			hresp = hresp_sram;
		end else if (dph_gpio) begin
			hrdata = hrdata_gpio;
			hready_resp = hready_resp_gpio;
			hresp = hresp_gpio;
		end else begin
			// Default slave: idle phases complete at once, unmapped ones error
			hrdata = '0;
			hready_resp = !err_first;
			hresp = (err_first || err_second) ? HRESP_ERROR : HRESP_OKAY;
		end
	end

	// At most one slave owns any data phase
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({dph_sram, dph_gpio, err_first || err_second}))
		else $error("more than one data-phase owner");

endmodule

`default_nettype wire

// ==== hw/ahb_sram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_sram_ctrl import soc_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hsel,
	input  logic       hready,
	input  addr_t      haddr,
	input  logic       hwrite,
	input  htrans_e    htrans,
	input  hsize_e     hsize,
	input  word_t      hwdata,
	output word_t      hrdata,
	output logic       hready_resp,
	output hresp_e     hresp,
	output sram_addr_t sram_addr,
	inout  wire half_t sram_dq,
	output logic       sram_ce_n,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic [1:0] sram_byte_n
);

	sram_state_e state;
	sram_state_e state_nxt;
	logic        start;
	logic        cycle;
	logic        dph_write;
	hsize_e      dph_size;
	logic [18:0] dph_addr;
	word_t       rdata_q;
	half_t       wr_half;

	assign start = hsel && hready && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
	// LOW and HIGH are the clocks that run an SRAM cycle
	assign cycle = (state == SRAM_LOW) || (state == SRAM_HIGH);

	always_comb begin
		state_nxt = state;
		case (state)
			SRAM_IDLE, SRAM_DONE: begin
				// Word transfers are aligned, so they always begin on the low half
				if (start)
					state_nxt = haddr[1] ? SRAM_HIGH : SRAM_LOW;
				else
					state_nxt = SRAM_IDLE;
			end
			SRAM_LOW: begin
				if (dph_size == HSIZE_WORD)
					state_nxt = SRAM_HIGH;
				else
					state_nxt = SRAM_DONE;
			end
			SRAM_HIGH: state_nxt = SRAM_DONE;
			default: state_nxt = SRAM_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SRAM_IDLE;
			dph_write <= 1'b0;
			dph_size <= HSIZE_BYTE;
			dph_addr <= '0;
		end else begin
			state <= state_nxt;
			if (start) begin
				dph_write <= hwrite;
				dph_size <= hsize;
				dph_addr <= haddr[18:0];
			end
		end
	end

	// Each half lands in its own AHB byte lanes
	always_ff @(posedge clk) begin
		if (cycle && !dph_write) begin
			if (state == SRAM_HIGH)
				rdata_q[31:16] <= sram_dq;
			else
				rdata_q[15:0] <= sram_dq;
		end
	end

	always_comb begin
		sram_byte_n = 2'b11;
		if (cycle) begin
			if (dph_size == HSIZE_BYTE)
				sram_byte_n = dph_addr[0] ? 2'b01 : 2'b10;
			else
				sram_byte_n = 2'b00;
		end
	end

	assign sram_addr = {dph_addr[18:2], state == SRAM_HIGH};
	assign sram_ce_n = !cycle;
	assign sram_oe_n = !(cycle && !dph_write);
	// Strobe spans the high phase of clk so it rises mid-cycle with
	// address and data still stable, and back-to-back halves get two edges
	assign sram_we_n = !(cycle && dph_write && clk);

	assign wr_half = (state == SRAM_HIGH) ? hwdata[31:16] : hwdata[15:0];
	assign sram_dq = (cycle && dph_write) ? wr_half : {16{1'bz}};

	assign hrdata = rdata_q;
	assign hready_resp = !cycle;
	assign hresp = HRESP_OKAY;

	// Sampled mid-cycle, where the write strobe is valid
	assert property (@(negedge clk) disable iff (!rst_n)
		!sram_we_n |-> sram_oe_n)
		else $error("sram we_n and oe_n low together");

	assert property (@(negedge clk) disable iff (!rst_n)
		!sram_we_n |-> !sram_ce_n)
		else $error("sram we_n low without ce_n");

endmodule

`default_nettype wire

// ==== hw/ahb_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_gpio import soc_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    hsel,
	input  logic    hready,
	input  addr_t   haddr,
	input  logic    hwrite,
	input  htrans_e htrans,
	input  hsize_e  hsize,
	input  word_t   hwdata,
	output word_t   hrdata,
	output logic    hready_resp,
	output hresp_e  hresp,
	output pads_t   padout,
	output pads_t   padoe,
	input  pads_t   padin
);

	logic       start;
	logic       dph_write;
	logic [3:0] dph_ofs;
	hsize_e     dph_size;
	logic [3:0] wstrb;
	word_t      wmask;
	pads_t      out_q;
	pads_t      oe_q;
	pads_t      in_meta;
	pads_t      in_sync;

	function automatic pads_t merge_lanes(pads_t old, word_t wdata, word_t mask);
		return (old & ~mask[N_PADS-1:0]) | (wdata[N_PADS-1:0] & mask[N_PADS-1:0]);
	endfunction

	assign start = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_write <= 1'b0;
			dph_ofs <= '0;
			dph_size <= HSIZE_BYTE;
		end else if (hready) begin
			dph_write <= start && hwrite;
			if (start) begin
				dph_ofs <= haddr[3:0];
				dph_size <= hsize;
			end
		end
	end

	always_comb begin
		case (dph_size)
			HSIZE_BYTE: wstrb = 4'b0001 << dph_ofs[1:0];
			HSIZE_HALF: wstrb = dph_ofs[1] ? 4'b1100 : 4'b0011;
			default:    wstrb = 4'b1111;
		endcase
	end

	assign wmask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

	// Writes to IN fall through and are dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_q <= '0;
			oe_q <= '0;
		end else if (dph_write && hready) begin
			if (dph_ofs[3:2] == GPIO_OUT_OFS[3:2])
				out_q <= merge_lanes(out_q, hwdata, wmask);
			else if (dph_ofs[3:2] == GPIO_OE_OFS[3:2])
				oe_q <= merge_lanes(oe_q, hwdata, wmask);
		end
	end

	// Two-stage synchronizer on the pad inputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			in_meta <= padin;
			in_sync <= in_meta;
		end
	end

	always_comb begin
		hrdata = '0;
		case (dph_ofs[3:2])
			GPIO_OUT_OFS[3:2]: hrdata[N_PADS-1:0] = out_q;
			GPIO_OE_OFS[3:2]:  hrdata[N_PADS-1:0] = oe_q;
			GPIO_IN_OFS[3:2]:  hrdata[N_PADS-1:0] = in_sync;
			default:           hrdata = '0;
		endcase
	end

	assign hready_resp = 1'b1;
	assign hresp = HRESP_OKAY;
	assign padout = out_q;
	assign padoe = oe_q;

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  addr_t      haddr,
	input  logic       hwrite,
	input  htrans_e    htrans,
	input  hsize_e     hsize,
	// Burst, protection and lock qualifiers are taken but have no effect
	input  logic [2:0] hburst,
	input  logic [3:0] hprot,
	input  logic       hmastlock,
	input  word_t      hwdata,
	output word_t      hrdata,
	output logic       hready,
	output hresp_e     hresp,
	output pads_t      padout,
	output pads_t      padoe,
	input  pads_t      padin,
	output sram_addr_t sram_addr,
	inout  wire half_t sram_dq,
	output logic       sram_ce_n,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic [1:0] sram_byte_n
);

	logic   hsel_sram;
	logic   hsel_gpio;
	word_t  hrdata_sram;
	word_t  hrdata_gpio;
	logic   hready_resp_sram;
	logic   hready_resp_gpio;
	hresp_e hresp_sram;
	hresp_e hresp_gpio;

	// The muxed response is the shared hready seen by every slave
	ahb_splitter splitter (
		.clk              (clk),
		.rst_n            (rst_n),
		.haddr            (haddr),
		.htrans           (htrans),
		.hready           (hready),
		.hsel_sram        (hsel_sram),
		.hsel_gpio        (hsel_gpio),
		.hrdata_sram      (hrdata_sram),
		.hrdata_gpio      (hrdata_gpio),
		.hready_resp_sram (hready_resp_sram),
		.hready_resp_gpio (hready_resp_gpio),
		.hresp_sram       (hresp_sram),
		.hresp_gpio       (hresp_gpio),
		.hrdata           (hrdata),
		.hready_resp      (hready),
		.hresp            (hresp)
	);

	ahb_sram_ctrl sram_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.hsel        (hsel_sram),
		.hready      (hready),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hsize       (hsize),
		.hwdata      (hwdata),
		.hrdata      (hrdata_sram),
		.hready_resp (hready_resp_sram),
		.hresp       (hresp_sram),
		.sram_addr   (sram_addr),
		.sram_dq     (sram_dq),
		.sram_ce_n   (sram_ce_n),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n),
		.sram_byte_n (sram_byte_n)
	);

	ahb_gpio gpio (
		.clk         (clk),
		.rst_n       (rst_n),
		.hsel        (hsel_gpio),
		.hready      (hready),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hsize       (hsize),
		.hwdata      (hwdata),
		.hrdata      (hrdata_gpio),
		.hready_resp (hready_resp_gpio),
		.hresp       (hresp_gpio),
		.padout      (padout),
		.padoe       (padoe),
		.padin       (padin)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram_model import soc_pkg::*; (
	input  sram_addr_t addr,
	inout  wire half_t dq,
	input  logic       ce_n,
	input  logic       we_n,
	input  logic       oe_n,
	input  logic [1:0] byte_n
);

	localparam int DEPTH = 2 ** $bits(sram_addr_t);

	half_t mem [0:DEPTH-1];
	half_t rd;
	time   we_fall;

	assign rd = mem[addr];

	// Reads drive only the enabled byte lanes, the other lane floats
	assign dq[7:0] = (!ce_n && !oe_n && we_n && !byte_n[0]) ? rd[7:0] : 8'hzz;
	assign dq[15:8] = (!ce_n && !oe_n && we_n && !byte_n[1]) ? rd[15:8] : 8'hzz;

	always @(negedge we_n) begin
		we_fall = $time;
	end

	// Data is latched as we_n rises
	// A strobe of zero width writes nothing
	always @(posedge we_n) begin
		if (!ce_n && ($time > we_fall)) begin
			if (!byte_n[0])
				mem[addr][7:0] = dq[7:0];
			if (!byte_n[1])
				mem[addr][15:8] = dq[15:8];
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb import soc_pkg::*; ();

	// The traffic needs under 3000 cycles and the limit roughly doubles that
	localparam int MAX_CYCLES = 6000;
	localparam addr_t GPIO_BASE = {GPIO_REGION, 28'h0};

	typedef struct packed {
		addr_t  addr;
		word_t  data;
		word_t  mask;
		hresp_e resp;
		int     waits;
	} expect_t;

	logic       clk;
	logic       rst_n;
	addr_t      haddr;
	logic       hwrite;
	htrans_e    htrans;
	hsize_e     hsize;
	logic [2:0] hburst;
	logic [3:0] hprot;
	logic       hmastlock;
	word_t      hwdata;
	word_t      hrdata;
	logic       hready;
	hresp_e     hresp;
	pads_t      padout;
	pads_t      padoe;
	pads_t      ext_en;
	pads_t      ext_val;
	wire [N_PADS-1:0] pad;
	sram_addr_t sram_addr;
	wire [15:0] sram_dq;
	logic       sram_ce_n;
	logic       sram_we_n;
	logic       sram_oe_n;
	logic [1:0] sram_byte_n;

	logic [7:0] mem_img [addr_t];
	expect_t    exp_q [$];
	int         checks = 0;
	int         mismatches = 0;
	int         failures = 0;
	int         cycles = 0;
	logic       in_dph = 1'b0;
	int         dph_waits = 0;

	soc_top UUT (
		.clk (clk), .rst_n (rst_n),
		.haddr (haddr), .hwrite (hwrite), .htrans (htrans), .hsize (hsize),
		.hburst (hburst), .hprot (hprot), .hmastlock (hmastlock),
		.hwdata (hwdata), .hrdata (hrdata), .hready (hready), .hresp (hresp),
		.padout (padout), .padoe (padoe), .padin (pad),
		.sram_addr (sram_addr), .sram_dq (sram_dq), .sram_ce_n (sram_ce_n),
		.sram_we_n (sram_we_n), .sram_oe_n (sram_oe_n), .sram_byte_n (sram_byte_n)
	);

	tb_sram_model sram (
		.addr (sram_addr), .dq (sram_dq), .ce_n (sram_ce_n),
		.we_n (sram_we_n), .oe_n (sram_oe_n), .byte_n (sram_byte_n)
	);

	// Pad buffers with pull-ups and an external driver per pad
	for (genvar p = 0; p < N_PADS; p++) begin : pad_buf
		assign pad[p] = padoe[p] ? padout[p] : 1'bz;
		assign pad[p] = ext_en[p] ? ext_val[p] : 1'bz;
		pullup (pad[p]);
	end

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: transfers still running after %0d cycles", MAX_CYCLES);
			failures++;
			print_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic word_t lane_mask(addr_t addr, hsize_e size);
		case (size)
			HSIZE_BYTE: return 32'hff << (8 * addr[1:0]);
			HSIZE_HALF: return addr[1] ? 32'hffff_0000 : 32'h0000_ffff;
			default:    return 32'hffff_ffff;
		endcase
	endfunction

	function automatic word_t ref_read(addr_t addr, hsize_e size);
		word_t mask;
		word_t data;
		addr_t base;
		mask = lane_mask(addr, size);
		base = {addr[31:2], 2'b00};
		data = '0;
		for (int i = 0; i < 4; i++)
			if (mask[8*i])
				data[8*i +: 8] = mem_img[base + i];
		return data;
	endfunction

	function automatic void ref_write(addr_t addr, hsize_e size, word_t wdata);
		word_t mask;
		addr_t base;
		mask = lane_mask(addr, size);
		base = {addr[31:2], 2'b00};
		for (int i = 0; i < 4; i++)
			if (mask[8*i])
				mem_img[base + i] = wdata[8*i +: 8];
	endfunction

	// Output enable wins, then the external driver, then the pull-up
	function automatic pads_t pad_levels(pads_t out, pads_t oe, pads_t en, pads_t val);
		return (oe & out) | (~oe & en & val) | (~oe & ~en);
	endfunction

	function automatic int sram_waits(hsize_e size);
		return (size == HSIZE_WORD) ? 2 : 1;
	endfunction

	function automatic addr_t aligned_offset(hsize_e size);
		case (size)
			HSIZE_BYTE: return $urandom_range(0, 3);
			HSIZE_HALF: return 2 * $urandom_range(0, 1);
			default:    return 0;
		endcase
	endfunction

	task automatic check_rdata(word_t exp, word_t act, word_t mask, string what);
		checks++;
		if ((act & mask) !== (exp & mask)) begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h on lanes %h",
				$time, what, act, exp, mask);
		end
	endtask

	task automatic check_resp(hresp_e exp, hresp_e act, string what);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %s, expected %s", $time, what, act.name(), exp.name());
		end
	endtask

	task automatic check_pads(pads_t exp, pads_t act, string what);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, act, exp);
		end
	endtask

	task automatic check_sram_addr(sram_addr_t exp, sram_addr_t act, string what);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, act, exp);
		end
	endtask

	task automatic check_waits(int exp, int act, string what);
		checks++;
		if (act != exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
		end
	endtask

	task automatic check_bit(logic exp, logic act, string what);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, act, exp);
		end
	endtask

	task automatic print_counts();
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
	endtask

	// Data-phase monitor sampled mid-cycle
	always @(negedge clk) begin : monitor
		expect_t e;
		if (rst_n && in_dph) begin
			e = exp_q[0];
			if (hready) begin
				void'(exp_q.pop_front());
				check_resp(e.resp, hresp, $sformatf("hresp for %h", e.addr));
				if (e.mask != '0)
					check_rdata(e.data, hrdata, e.mask, $sformatf("hrdata for %h", e.addr));
				check_waits(e.waits, dph_waits, $sformatf("wait states for %h", e.addr));
				in_dph = 1'b0;
			end else begin
				check_resp(e.resp, hresp, $sformatf("wait-state hresp for %h", e.addr));
				// Halves run low first, so the wait count picks the half of a word
				if (e.addr[SLAVE_SEL_MSB:SLAVE_SEL_LSB] == SRAM_REGION)
					check_sram_addr({e.addr[18:2], e.addr[1] | dph_waits[0]}, sram_addr,
						$sformatf("sram_addr for %h", e.addr));
				dph_waits++;
			end
		end
		if (rst_n && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ)) begin
			if (exp_q.size() == 0) begin
				failures++;
				$display("address phase at %0t with no transfer expected", $time);
			end else begin
				in_dph = 1'b1;
				dph_waits = 0;
			end
		end
	end

	task automatic wait_ready();
		logic rdy;
		rdy = 1'b0;
		while (!rdy) begin
			@(negedge clk);
			rdy = hready;
			@(posedge clk);
		end
	endtask

	// One address phase and its data phase, driven and awaited on rising edges
	task automatic ahb_xfer(addr_t addr, logic write, hsize_e size, word_t wdata,
			word_t exp_data, hresp_e exp_resp, int exp_waits);
		expect_t e;
		e.addr = addr;
		e.data = exp_data;
		e.mask = (write || exp_resp == HRESP_ERROR) ? '0 : lane_mask(addr, size);
		e.resp = exp_resp;
		e.waits = exp_waits;
		exp_q.push_back(e);
		haddr <= addr;
		hwrite <= write;
		hsize <= size;
		htrans <= HTRANS_NONSEQ;
		wait_ready();
		htrans <= HTRANS_IDLE;
		hwdata <= wdata;
		wait_ready();
	endtask

	task automatic sram_write(addr_t addr, hsize_e size, word_t wdata);
		ahb_xfer(addr, 1'b1, size, wdata, '0, HRESP_OKAY, sram_waits(size));
		ref_write(addr, size, wdata);
	endtask

	task automatic sram_read(addr_t addr, hsize_e size);
		ahb_xfer(addr, 1'b0, size, $urandom, ref_read(addr, size), HRESP_OKAY, sram_waits(size));
	endtask

	task automatic gpio_write(addr_t ofs, hsize_e size, word_t wdata);
		ahb_xfer(GPIO_BASE + ofs, 1'b1, size, wdata, '0, HRESP_OKAY, 0);
	endtask

	task automatic gpio_read(addr_t ofs, pads_t exp);
		ahb_xfer(GPIO_BASE + ofs, 1'b0, HSIZE_WORD, $urandom, exp, HRESP_OKAY, 0);
	endtask

	initial begin : stimulus
		addr_t      words [$];
		addr_t      addr;
		addr_t      ofs;
		word_t      wdata;
		word_t      merged;
		hsize_e     size;
		pads_t      out_ref;
		pads_t      oe_ref;
		logic [3:0] region;
		clk = 1'b0;
		rst_n = 1'b0;
		haddr = '0;
		hwrite = 1'b0;
		htrans = HTRANS_IDLE;
		hsize = HSIZE_WORD;
		hburst = 3'b000;
		hprot = 4'b0011;
		hmastlock = 1'b0;
		hwdata = '0;
		ext_en = '0;
		ext_val = '0;
		out_ref = '0;
		oe_ref = '0;
		void'($urandom(86637));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		@(negedge clk);
		check_bit(1'b1, hready, "hready after reset");
		check_resp(HRESP_OKAY, hresp, "hresp after reset");
		check_pads('0, padout, "padout after reset");
		check_pads('0, padoe, "padoe after reset");
		check_bit(1'b1, sram_ce_n, "sram_ce_n after reset");
		check_bit(1'b1, sram_we_n, "sram_we_n after reset");
		check_bit(1'b1, sram_oe_n, "sram_oe_n after reset");
		check_bit(1'b1, sram_byte_n === 2'b11, "sram_byte_n all ones after reset");
		@(posedge clk);

		// Word traffic to random SRAM locations
		repeat (100) begin
			addr = $urandom & 32'h0007_fffc;
			words.push_back(addr);
			sram_write(addr, HSIZE_WORD, $urandom);
		end
		foreach (words[i])
			sram_read(words[i], HSIZE_WORD);

		// Sub-word writes merged into known words and read back at every size
		repeat (40) begin
			addr = $urandom & 32'h0007_fffc;
			sram_write(addr, HSIZE_WORD, $urandom);
			repeat (4) begin
				size = $urandom_range(0, 1) ? HSIZE_HALF : HSIZE_BYTE;
				sram_write(addr + aligned_offset(size), size, $urandom);
			end
			sram_read(addr, HSIZE_WORD);
			sram_read(addr, HSIZE_HALF);
			sram_read(addr + 2, HSIZE_HALF);
			for (int b = 0; b < 4; b++)
				sram_read(addr + b, HSIZE_BYTE);
		end

		// GPIO registers and pad levels
		repeat (20) begin
			size = hsize_e'($urandom_range(0, 2));
			ofs = aligned_offset(size);
			wdata = $urandom;
			gpio_write(GPIO_OUT_OFS + ofs, size, wdata);
			merged = ({9'h0, out_ref} & ~lane_mask(ofs, size)) | (wdata & lane_mask(ofs, size));
			out_ref = merged[N_PADS-1:0];
			wdata = $urandom;
			gpio_write(GPIO_OE_OFS, HSIZE_WORD, wdata);
			oe_ref = wdata[N_PADS-1:0];
			ext_en <= pads_t'($urandom) & ~oe_ref;
			ext_val <= pads_t'($urandom);
			repeat (3) @(posedge clk);
			@(negedge clk);
			check_pads(out_ref, padout, "padout");
			check_pads(oe_ref, padoe, "padoe");
			check_pads(pad_levels(out_ref, oe_ref, ext_en, ext_val), pad, "pad levels");
			@(posedge clk);
			gpio_read(GPIO_OUT_OFS, out_ref);
			gpio_read(GPIO_OE_OFS, oe_ref);
			gpio_read(GPIO_IN_OFS, pad_levels(out_ref, oe_ref, ext_en, ext_val));
		end

		// Unmapped accesses each followed by normal traffic
		repeat (8) begin
			do
				region = $urandom;
			while (region == SRAM_REGION || region == GPIO_REGION);
			addr = {region, 28'($urandom)} & ~32'h3;
			ahb_xfer(addr, $urandom_range(0, 1), HSIZE_WORD, $urandom, '0, HRESP_ERROR, 1);
			sram_read(words[$urandom_range(0, words.size() - 1)], HSIZE_WORD);
			addr = GPIO_BASE + (32'($urandom_range(3, 4095)) << 2);
			ahb_xfer(addr, $urandom_range(0, 1), HSIZE_WORD, $urandom, '0, HRESP_ERROR, 1);
			gpio_read(GPIO_OUT_OFS, out_ref);
		end
		// IN is read-only
		gpio_write(GPIO_IN_OFS, HSIZE_WORD, $urandom);
		gpio_read(GPIO_OUT_OFS, out_ref);
		gpio_read(GPIO_OE_OFS, oe_ref);

		repeat (2) @(posedge clk);
		if (exp_q.size() != 0) begin
			failures++;
			$display("%0d transfers never completed their data phase", exp_q.size());
		end
		print_counts();
		if (mismatches == 0 && failures == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/soc_pkg.sv
hw/ahb_splitter.sv
hw/ahb_sram_ctrl.sv
hw/ahb_gpio.sv
hw/soc_top.sv
testbench/tb_sram_model.sv
testbench/tb.sv
